// File: common/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opBeq   = 6'h04,
    opAddiu = 6'h09,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // Function codes under opRtype
  typedef enum logic [5:0] {
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnSlt  = 6'h2a
  } functT;

  // Instruction field positions
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 26;
  localparam int rsMsb     = 25;
  localparam int rsLsb     = 21;
  localparam int rtMsb     = 20;
  localparam int rtLsb     = 16;
  localparam int rdMsb     = 15;
  localparam int rdLsb     = 11;
  localparam int functMsb  = 5;
  localparam int functLsb  = 0;
  localparam int immMsb    = 15;
  localparam int immLsb    = 0;

  // sll $0,$0,0 decodes as a bubble
  localparam logic [31:0] nopWord = 32'h0000_0000;

endpackage

`default_nettype wire

// File: common/mipsPipePkg.sv
`default_nettype none

package mipsPipePkg;

  // ALU operation selected by decode
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  // Word-addressed memories
  localparam int imemDepth    = 256;
  localparam int dmemDepth    = 256;
  localparam int imemAddrBits = 8;
  localparam int dmemAddrBits = 8;

  // Architectural registers
  localparam int regCount = 32;

endpackage

`default_nettype wire

// File: fetch/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch import mipsPipePkg::*; (
  input  logic                    Clock,
  input  logic                    rst,
  input  logic                    progValid,
  input  logic [imemAddrBits-1:0] progAddr,
  input  logic [31:0]             progData,
  input  logic                    branchTaken,
  input  logic [31:0]             branchTarget,
  output logic [31:0]             pcOut,
  output logic [31:0]             instrId,
  output logic [31:0]             pcPlusFourId,
  output logic                    validId
);

  logic [31:0] pcReg;
  logic [31:0] pcPlusFour;
  logic [31:0] imem [imemDepth];

  assign pcPlusFour = pcReg + 32'd4;
  assign pcOut      = pcReg;

  // Program load only while the core is held in reset
  always_ff @(posedge Clock) begin
    if (rst && progValid) begin
      imem[progAddr] <= progData;
    end
  end

  // Redirect comes from the memory stage
  // Delay slots already fetched still issue
  always_ff @(posedge Clock) begin
    if (rst) begin
      pcReg   <= '0;
      validId <= 1'b0;
    end else begin
      pcReg   <= branchTaken ? branchTarget : pcPlusFour;
      validId <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge Clock) begin
    instrId      <= imem[pcReg[imemAddrBits+1:2]];
    pcPlusFourId <= pcPlusFour;
  end

endmodule

`default_nettype wire

// File: decode/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPipePkg::*; (
  input  logic        Clock,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  output logic [31:0] rsData,
  output logic [31:0] rtData,
  input  logic        wbValid,
  input  logic [4:0]  wbReg,
  input  logic [31:0] wbData
);

  logic [31:0] regs [regCount];
  logic        wrEn;

  // Register 0 never takes a write
  assign wrEn = wbValid && (wbReg != 5'd0);

  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wbReg] <= wbData;
    end
  end

  // Same-cycle write passes straight to the reader
  assign rsData = (wrEn && wbReg == rsAddr) ? wbData : regs[rsAddr];
  assign rtData = (wrEn && wbReg == rtAddr) ? wbData : regs[rtAddr];

endmodule

`default_nettype wire

// File: decode/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode import mipsIsaPkg::*, mipsPipePkg::*; (
  input  logic        Clock,
  input  logic        rst,
  input  logic [31:0] instrId,
  input  logic [31:0] pcPlusFourId,
  input  logic        validId,
  input  logic        wbValid,
  input  logic [4:0]  wbReg,
  input  logic [31:0] wbData,
  output logic        regWriteEx,
  output logic        memToRegEx,
  output logic        memReadEx,
  output logic        memWriteEx,
  output logic        branchEx,
  output logic        aluSrcImmEx,
  output logic        regDstRdEx,
  output aluOpT       aluOpEx,
  output logic [31:0] rsDataEx,
  output logic [31:0] rtDataEx,
  output logic [31:0] immEx,
  output logic [4:0]  rtEx,
  output logic [4:0]  rdEx,
  output logic [31:0] pcPlusFourEx,
  output logic        validEx
);

  opcodeT      opcode;
  functT       funct;
  logic [31:0] rsData, rtData, immExt;
  logic        regWrite, memToReg, memRead, memWrite, branch, aluSrcImm, regDstRd;
  aluOpT       aluOp;

  assign opcode = opcodeT'(instrId[opcodeMsb:opcodeLsb]);
  assign funct  = functT'(instrId[functMsb:functLsb]);
  assign immExt = {{16{instrId[immMsb]}}, instrId[immMsb:immLsb]};

  regFile u_regFile (
    .Clock  (Clock),
    .rst    (rst),
    .rsAddr (instrId[rsMsb:rsLsb]),
    .rtAddr (instrId[rtMsb:rtLsb]),
    .rsData (rsData),
    .rtData (rtData),
    .wbValid(wbValid),
    .wbReg  (wbReg),
    .wbData (wbData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    regWrite  = 1'b0;
    memToReg  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    branch    = 1'b0;
    aluSrcImm = 1'b0;
    regDstRd  = 1'b0;
    aluOp     = aluAdd;
    case (opcode)
      opRtype: begin
        regDstRd = 1'b1;
        regWrite = 1'b1;
        case (funct)
          fnAddu:  aluOp = aluAdd;
          fnSubu:  aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          // Unknown funct (and the nop) is a bubble
          default: begin
            regDstRd = 1'b0;
            regWrite = 1'b0;
          end
        endcase
      end
      opAddiu: begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
      end
      opLw: begin
        regWrite  = 1'b1;
        memToReg  = 1'b1;
        memRead   = 1'b1;
        aluSrcImm = 1'b1;
      end
      opSw: begin
        memWrite  = 1'b1;
        aluSrcImm = 1'b1;
      end
      opBeq: begin
        branch = 1'b1;
        aluOp  = aluSub;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock) begin
    if (rst) begin
      regWriteEx  <= 1'b0;
      memToRegEx  <= 1'b0;
      memReadEx   <= 1'b0;
      memWriteEx  <= 1'b0;
      branchEx    <= 1'b0;
      aluSrcImmEx <= 1'b0;
      regDstRdEx  <= 1'b0;
      aluOpEx     <= aluAdd;
      validEx     <= 1'b0;
    end else begin
      regWriteEx  <= regWrite;
      memToRegEx  <= memToReg;
      memReadEx   <= memRead;
      memWriteEx  <= memWrite;
      branchEx    <= branch;
      aluSrcImmEx <= aluSrcImm;
      regDstRdEx  <= regDstRd;
      aluOpEx     <= aluOp;
      validEx     <= validId;
    end
  end

  always_ff @(posedge Clock) begin
    rsDataEx     <= rsData;
    rtDataEx     <= rtData;
    immEx        <= immExt;
    rtEx         <= instrId[rtMsb:rtLsb];
    rdEx         <= instrId[rdMsb:rdLsb];
    pcPlusFourEx <= pcPlusFourId;
  end

endmodule

`default_nettype wire

// File: execute/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage import mipsPipePkg::*; (
  input  logic        Clock,
  input  logic        rst,
  input  logic        regWriteEx,
  input  logic        memToRegEx,
  input  logic        memReadEx,
  input  logic        memWriteEx,
  input  logic        branchEx,
  input  logic        aluSrcImmEx,
  input  logic        regDstRdEx,
  input  aluOpT       aluOpEx,
  input  logic [31:0] rsDataEx,
  input  logic [31:0] rtDataEx,
  input  logic [31:0] immEx,
  input  logic [4:0]  rtEx,
  input  logic [4:0]  rdEx,
  input  logic [31:0] pcPlusFourEx,
  input  logic        validEx,
  output logic        regWriteMem,
  output logic        memToRegMem,
  output logic        memReadMem,
  output logic        memWriteMem,
  output logic        branchMem,
  output logic [31:0] aluResultMem,
  output logic [31:0] storeDataMem,
  output logic [4:0]  destRegMem,
  output logic [31:0] branchTargetMem,
  output logic        zeroMem,
  output logic        validMem
);

  logic [31:0] opB;
  logic [31:0] aluResult;

  assign opB = aluSrcImmEx ? immEx : rtDataEx;

  always_comb begin
    case (aluOpEx)
      aluAdd:  aluResult = rsDataEx + opB;
      aluSub:  aluResult = rsDataEx - opB;
      aluAnd:  aluResult = rsDataEx & opB;
      aluOr:   aluResult = rsDataEx | opB;
      // Signed compare for slt
      aluSlt:  aluResult = {31'd0, $signed(rsDataEx) < $signed(opB)};
      default: aluResult = '0;
    endcase
  end

  // EX/MEM control
  always_ff @(posedge Clock) begin
    if (rst) begin
      regWriteMem <= 1'b0;
      memToRegMem <= 1'b0;
      memReadMem  <= 1'b0;
      memWriteMem <= 1'b0;
      branchMem   <= 1'b0;
      validMem    <= 1'b0;
    end else begin
      regWriteMem <= regWriteEx;
      memToRegMem <= memToRegEx;
      memReadMem  <= memReadEx;
      memWriteMem <= memWriteEx;
      branchMem   <= branchEx;
      validMem    <= validEx;
    end
  end

  // EX/MEM payload
  // Branch target is a word offset from pc+4
  always_ff @(posedge Clock) begin
    aluResultMem    <= aluResult;
    storeDataMem    <= rtDataEx;
    destRegMem      <= regDstRdEx ? rdEx : rtEx;
    branchTargetMem <= pcPlusFourEx + {immEx[29:0], 2'b00};
    zeroMem         <= (rsDataEx == rtDataEx);
  end

endmodule

`default_nettype wire

// File: memory/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage import mipsPipePkg::*; (
  input  logic        Clock,
  input  logic        rst,
  input  logic        regWriteMem,
  input  logic        memToRegMem,
  input  logic        memReadMem,
  input  logic        memWriteMem,
  input  logic        branchMem,
  input  logic [31:0] aluResultMem,
  input  logic [31:0] storeDataMem,
  input  logic [4:0]  destRegMem,
  input  logic [31:0] branchTargetMem,
  input  logic        zeroMem,
  input  logic        validMem,
  output logic        branchTaken,
  output logic [31:0] branchTarget,
  output logic        stValid,
  output logic [31:0] stAddr,
  output logic [31:0] stData,
  output logic [31:0] readDataWb,
  output logic [31:0] aluResultWb,
  output logic [4:0]  destRegWb,
  output logic        regWriteWb,
  output logic        memToRegWb,
  output logic        validWb
);

  logic [31:0]             dmem [dmemDepth];
  logic [dmemAddrBits-1:0] wordIdx;

  assign wordIdx = aluResultMem[dmemAddrBits+1:2];

  // Branch decision goes back to fetch in this cycle
  assign branchTaken  = branchMem && zeroMem && validMem;
  assign branchTarget = branchTargetMem;

  assign stValid = memWriteMem && validMem;
  assign stAddr  = aluResultMem;
  assign stData  = storeDataMem;

  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < dmemDepth; i++) begin
        dmem[i] <= '0;
      end
    end else if (stValid) begin
      dmem[wordIdx] <= storeDataMem;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clock) begin
    if (rst) begin
      regWriteWb <= 1'b0;
      memToRegWb <= 1'b0;
      validWb    <= 1'b0;
    end else begin
      regWriteWb <= regWriteMem;
      memToRegWb <= memToRegMem;
      validWb    <= validMem;
    end
  end

  always_ff @(posedge Clock) begin
    readDataWb  <= memReadMem ? dmem[wordIdx] : '0;
    aluResultWb <= aluResultMem;
    destRegWb   <= destRegMem;
  end

endmodule

`default_nettype wire

// File: source/mipsPipeTop.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeTop import mipsPipePkg::*; (
  input  logic                    Clock,
  input  logic                    rst,
  input  logic                    progValid,
  input  logic [imemAddrBits-1:0] progAddr,
  input  logic [31:0]             progData,
  output logic [31:0]             pcOut,
  output logic                    wbValid,
  output logic [4:0]              wbReg,
  output logic [31:0]             wbData,
  output logic                    stValid,
  output logic [31:0]             stAddr,
  output logic [31:0]             stData
);

  // Fetch to decode
  logic [31:0] instrId, pcPlusFourId;
  logic        validId;
  // Decode to execute
  logic        regWriteEx, memToRegEx, memReadEx, memWriteEx, branchEx;
  logic        aluSrcImmEx, regDstRdEx, validEx;
  aluOpT       aluOpEx;
  logic [31:0] rsDataEx, rtDataEx, immEx, pcPlusFourEx;
  logic [4:0]  rtEx, rdEx;
  // Execute to memory
  logic        regWriteMem, memToRegMem, memReadMem, memWriteMem, branchMem;
  logic        zeroMem, validMem;
  logic [31:0] aluResultMem, storeDataMem, branchTargetMem;
  logic [4:0]  destRegMem;
  // Memory to fetch and write-back
  logic        branchTaken;
  logic [31:0] branchTarget;
  logic [31:0] readDataWb, aluResultWb;
  logic [4:0]  destRegWb;
  logic        regWriteWb, memToRegWb, validWb;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  instrFetch u_fetch (
    .Clock(Clock), .rst(rst),
    .progValid(progValid), .progAddr(progAddr), .progData(progData),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .pcOut(pcOut), .instrId(instrId), .pcPlusFourId(pcPlusFourId), .validId(validId)
  );

  instrDecode u_decode (
    .Clock(Clock), .rst(rst),
    .instrId(instrId), .pcPlusFourId(pcPlusFourId), .validId(validId),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .regWriteEx(regWriteEx), .memToRegEx(memToRegEx), .memReadEx(memReadEx),
    .memWriteEx(memWriteEx), .branchEx(branchEx), .aluSrcImmEx(aluSrcImmEx),
    .regDstRdEx(regDstRdEx), .aluOpEx(aluOpEx),
    .rsDataEx(rsDataEx), .rtDataEx(rtDataEx), .immEx(immEx),
    .rtEx(rtEx), .rdEx(rdEx), .pcPlusFourEx(pcPlusFourEx), .validEx(validEx)
  );

  execStage u_exec (
    .Clock(Clock), .rst(rst),
    .regWriteEx(regWriteEx), .memToRegEx(memToRegEx), .memReadEx(memReadEx),
    .memWriteEx(memWriteEx), .branchEx(branchEx), .aluSrcImmEx(aluSrcImmEx),
    .regDstRdEx(regDstRdEx), .aluOpEx(aluOpEx),
    .rsDataEx(rsDataEx), .rtDataEx(rtDataEx), .immEx(immEx),
    .rtEx(rtEx), .rdEx(rdEx), .pcPlusFourEx(pcPlusFourEx), .validEx(validEx),
    .regWriteMem(regWriteMem), .memToRegMem(memToRegMem), .memReadMem(memReadMem),
    .memWriteMem(memWriteMem), .branchMem(branchMem),
    .aluResultMem(aluResultMem), .storeDataMem(storeDataMem), .destRegMem(destRegMem),
    .branchTargetMem(branchTargetMem), .zeroMem(zeroMem), .validMem(validMem)
  );

  memStage u_mem (
    .Clock(Clock), .rst(rst),
    .regWriteMem(regWriteMem), .memToRegMem(memToRegMem), .memReadMem(memReadMem),
    .memWriteMem(memWriteMem), .branchMem(branchMem),
    .aluResultMem(aluResultMem), .storeDataMem(storeDataMem), .destRegMem(destRegMem),
    .branchTargetMem(branchTargetMem), .zeroMem(zeroMem), .validMem(validMem),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .stValid(stValid), .stAddr(stAddr), .stData(stData),
    .readDataWb(readDataWb), .aluResultWb(aluResultWb), .destRegWb(destRegWb),
    .regWriteWb(regWriteWb), .memToRegWb(memToRegWb), .validWb(validWb)
  );

  // Write-back selection
  assign wbData  = memToRegWb ? readDataWb : aluResultWb;
  assign wbReg   = destRegWb;
  assign wbValid = regWriteWb && validWb;

endmodule

`default_nettype wire

// File: test/mipsPipe_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeChk (
  input logic        Clock,
  input logic        rst,
  input logic [31:0] pcOut,
  input logic        wbValid,
  input logic        stValid,
  input logic        regWriteMem
);

  // Pipeline registers clear one edge into reset
  resetQuiet: assert property (@(posedge Clock) $past(rst) |-> (!wbValid && !stValid))
    else $error("Write-back or store port active during reset");

  pcAligned: assert property (@(posedge Clock) !rst |-> (pcOut[1:0] == 2'b00))
    else $error("pcOut is not word-aligned");

  // A store never writes a register
  storeNoRegWrite: assert property (@(posedge Clock) stValid |-> !regWriteMem)
    else $error("Store also marked as a register write");

endmodule

bind mipsPipeTop mipsPipeChk i_chk (
  .Clock      (Clock),
  .rst        (rst),
  .pcOut      (pcOut),
  .wbValid    (wbValid),
  .stValid    (stValid),
  .regWriteMem(regWriteMem)
);

`default_nettype wire

// File: test/mipsPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeTb import mipsIsaPkg::*, mipsPipePkg::*; ();

  localparam int progWords  = 16;
  localparam int finalIdx   = 12;
  localparam int roundCount = 40;
  localparam int drainLimit = 100;

  logic                    Clock;
  logic                    rst;
  logic                    progValid;
  logic [imemAddrBits-1:0] progAddr;
  logic [31:0]             progData;
  logic [31:0]             pcOut;
  logic                    wbValid;
  logic [4:0]              wbReg;
  logic [31:0]             wbData;
  logic                    stValid;
  logic [31:0]             stAddr;
  logic [31:0]             stData;

  // Generated program and hazard bookkeeping
  logic [31:0] prog   [progWords];
  logic [4:0]  destOf [progWords];
  int          brTgt  [progWords];

  // Reference model state and expected events
  logic [31:0] mRegs [regCount];
  logic [31:0] mMem  [logic [31:0]];
  logic [31:0] pcQ[$];
  logic [31:0] wbRegQ[$];
  logic [31:0] wbDataQ[$];
  logic [31:0] stAddrQ[$];
  logic [31:0] stDataQ[$];

  mipsPipeTop i_dut (
    .Clock    (Clock),
    .rst      (rst),
    .progValid(progValid),
    .progAddr (progAddr),
    .progData (progData),
    .pcOut    (pcOut),
    .wbValid  (wbValid),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .stValid  (stValid),
    .stAddr   (stAddr),
    .stData   (stData)
  );

  initial begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program generator
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input functT fn);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input opcodeT op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic functT randFunct();
    case ($urandom_range(0, 4))
      0:       return fnAddu;
      1:       return fnSubu;
      2:       return fnAnd;
      3:       return fnOr;
      default: return fnSlt;
    endcase
  endfunction

  // Written by one of the two instructions executed just before index j
  function automatic bit isBusy(input logic [4:0] r, input int j);
    bit busy;
    busy = 1'b0;
    if (r == 5'd0) return 1'b0;
    if (j >= 1 && destOf[j-1] == r) busy = 1'b1;
    if (j >= 2 && destOf[j-2] == r) busy = 1'b1;
    // Taken branch puts its last delay slots right before the target
    for (int b = 0; b < j; b++) begin
      if (brTgt[b] == j && (destOf[b+2] == r || destOf[b+3] == r)) busy = 1'b1;
      if (brTgt[b] == j - 1 && destOf[b+3] == r) busy = 1'b1;
    end
    return busy;
  endfunction

  task automatic buildProgram();
    int          kind;
    int          lastBr;
    int          tgt;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm, memImm;
    for (int j = 0; j < progWords; j++) begin
      prog[j]   = nopWord;
      destOf[j] = 5'd0;
      brTgt[j]  = -1;
    end
    lastBr = -8;
    for (int j = 0; j < finalIdx; j++) begin
      kind   = $urandom_range(0, 9);
      rs     = 5'($urandom_range(0, 7));
      rt     = 5'($urandom_range(0, 7));
      rd     = 5'($urandom_range(0, 7));
      imm    = 16'($urandom);
      memImm = 16'($urandom_range(0, 3) * (dmemDepth / 4) * 4);
      // No branch inside delay slots or too close to the end
      if (kind >= 7 && kind <= 8 && (j > finalIdx - 4 || j - lastBr < 4)) kind = 3;
      case (kind)
        0, 1, 2: if (!isBusy(rs, j) && !isBusy(rt, j)) begin
          prog[j]   = encR(rs, rt, rd, randFunct());
          destOf[j] = rd;
        end
        3, 4: if (!isBusy(rs, j)) begin
          prog[j]   = encI(opAddiu, rs, rd, imm);
          destOf[j] = rd;
        end
        5: begin
          prog[j]   = encI(opLw, 5'd0, rd, memImm);
          destOf[j] = rd;
        end
        6: if (!isBusy(rt, j)) prog[j] = encI(opSw, 5'd0, rt, memImm);
        7, 8: if (!isBusy(rs, j) && !isBusy(rt, j)) begin
          tgt      = j + 4 + $urandom_range(0, finalIdx - j - 4);
          prog[j]  = encI(opBeq, rs, rt, 16'(tgt - j - 1));
          brTgt[j] = tgt;
          lastBr   = j;
        end
        default: ;
      endcase
    end
    // Self loop on register 0
    // Its delay slots stay nops
    prog[finalIdx] = encI(opBeq, 5'd0, 5'd0, 16'hffff);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // ISA model with three delay slots
  ////////////////////////////////////////////////////////////////////////////

  task automatic recordWrite(input logic [4:0] dst, input logic [31:0] val);
    wbRegQ.push_back(32'(dst));
    wbDataQ.push_back(val);
    // Register 0 shows on the port but keeps reading zero
    if (dst != 5'd0) mRegs[dst] = val;
  endtask

  task automatic runModel();
    logic [31:0] pc, nextPc, w, a, b, imm, addr, tgt;
    logic [5:0]  op;
    bit          taken;
    int          pending, tail, steps;
    for (int r = 0; r < regCount; r++) mRegs[r] = '0;
    mMem.delete();
    pcQ.delete();
    wbRegQ.delete();
    wbDataQ.delete();
    stAddrQ.delete();
    stDataQ.delete();
    pc      = '0;
    tgt     = '0;
    pending = 0;
    tail    = 0;
    steps   = 0;
    while (tail < 9 && steps < 200) begin
      pcQ.push_back(pc);
      if (pc == 32'(4 * finalIdx) || tail > 0) tail++;
      w     = prog[pc[5:2]];
      op    = w[31:26];
      a     = mRegs[w[25:21]];
      b     = mRegs[w[20:16]];
      imm   = {{16{w[15]}}, w[15:0]};
      addr  = a + imm;
      taken = 1'b0;
      case (op)
        opRtype: case (w[5:0])
          fnAddu:  recordWrite(w[15:11], a + b);
          fnSubu:  recordWrite(w[15:11], a - b);
          fnAnd:   recordWrite(w[15:11], a & b);
          fnOr:    recordWrite(w[15:11], a | b);
          fnSlt:   recordWrite(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          default: ;
        endcase
        opAddiu: recordWrite(w[20:16], addr);
        opLw:    recordWrite(w[20:16], mMem.exists(addr) ? mMem[addr] : 32'd0);
        opSw: begin
          stAddrQ.push_back(addr);
          stDataQ.push_back(b);
          mMem[addr] = b;
        end
        opBeq: if (a == b) begin
          taken = 1'b1;
          tgt   = pc + 32'd4 + (imm << 2);
        end
        default: ;
      endcase
      nextPc = pc + 32'd4;
      if (taken) begin
        pending = 3;
      end else if (pending > 0) begin
        pending--;
        if (pending == 0) nextPc = tgt;
      end
      pc = nextPc;
      steps++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkEq(input string testName, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    assert (actVal === expVal) else begin
      $display("ERR %s expected %08h actual %08h", testName, expVal, actVal);
      abortRun();
    end
  endtask

  task automatic expectPending(input int depth, input string what);
    assert (depth > 0) else begin
      $display("Unexpected %s while the model expected nothing more", what);
      abortRun();
    end
  endtask

  task automatic checkReset();
    checkEq("resetPc", 32'd0, pcOut);
    checkEq("resetWbValid", 32'd0, 32'(wbValid));
    checkEq("resetStValid", 32'd0, 32'(stValid));
  endtask

  task automatic compareCycle();
    if (pcQ.size() > 0) checkEq("pcSequence", pcQ.pop_front(), pcOut);
    if (wbValid) begin
      expectPending(wbRegQ.size(), "register write");
      checkEq("wbReg", wbRegQ.pop_front(), 32'(wbReg));
      checkEq("wbData", wbDataQ.pop_front(), wbData);
    end
    if (stValid) begin
      expectPending(stAddrQ.size(), "store");
      checkEq("stAddr", stAddrQ.pop_front(), stAddr);
      checkEq("stData", stDataQ.pop_front(), stData);
    end
  endtask

  task automatic runRound();
    int cycles;
    buildProgram();
    runModel();
    // Load one word per reset cycle, then release
    for (int i = 0; i <= progWords; i++) begin
      @(posedge Clock);
      #5;
      if (i > 0) checkReset();
      if (i < progWords) begin
        rst       = 1'b1;
        progValid = 1'b1;
        progAddr  = imemAddrBits'(i);
        progData  = prog[i];
      end else begin
        rst       = 1'b0;
        progValid = 1'b0;
      end
    end
    compareCycle();
    cycles = 0;
    while (pcQ.size() + wbRegQ.size() + stAddrQ.size() > 0) begin
      @(posedge Clock);
      #5;
      compareCycle();
      cycles++;
      if (cycles > drainLimit) begin
        $display("Timeout: pipeline stalled, expected events never arrived");
        abortRun();
      end
    end
    // Final loop must stay quiet
    repeat (4) begin
      @(posedge Clock);
      #5;
      compareCycle();
    end
  endtask

  initial begin
    rst       = 1'b1;
    progValid = 1'b0;
    progAddr  = '0;
    progData  = '0;
    void'($urandom(32'h6cb1_6bb5));
    for (int r = 0; r < roundCount; r++) begin
      runRound();
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: mipsPipe.f
common/mipsIsaPkg.sv
common/mipsPipePkg.sv
fetch/instrFetch.sv
decode/regFile.sv
decode/instrDecode.sv
execute/execStage.sv
memory/memStage.sv
source/mipsPipeTop.sv
test/mipsPipe_chk.sv
test/mipsPipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsPipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module mipsPipeTb --Mdir obj_dir -o mipsPipeSim \
  -f mipsPipe.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mipsPipeSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "All tests passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
